/* src/i2c_master_pkg.sv */
// i2c master shared widths, register map, bit commands and bundle types
package i2c_master_pkg;

	localparam int PRESCALE_W = 16;	// prescale register width
	localparam int ADDR_W = 6;	// register bus address
	localparam int DATA_W = 8;	// register bus data

	// register offsets from the base address
	localparam logic [ADDR_W-1:0] REG_PRER_LO = 0;
	localparam logic [ADDR_W-1:0] REG_PRER_HI = 1;
	localparam logic [ADDR_W-1:0] REG_CTR = 2;
	localparam logic [ADDR_W-1:0] REG_TXR = 3;
	localparam logic [ADDR_W-1:0] REG_RXR = 4;
	localparam logic [ADDR_W-1:0] REG_CR = 5;
	localparam logic [ADDR_W-1:0] REG_SR = 6;

	// commands from the byte engine to the bit engine
	typedef enum logic [2:0] {
		CMD_NOP = 3'd0,
		CMD_START = 3'd1,
		CMD_STOP = 3'd2,
		CMD_WRITE = 3'd3,
		CMD_READ = 3'd4
	} bit_cmd_e;

	// command register bits as seen by the byte engine
	typedef struct packed {
		logic start;
		logic stop;
		logic read;
		logic write;
		logic ack_in;	// ack bit sent after a read, 1 is nack
	} byte_req_t;

	typedef struct packed {
		logic done;	// single cycle pulse
		logic ack_out;	// ack seen from the slave
		logic [DATA_W-1:0] rx_data;
	} byte_rsp_t;

	typedef struct packed {
		logic scl;
		logic sda;
		logic scl_rise;
		logic rx_bit;	// sda taken on the scl rise
	} line_state_t;

endpackage

/* src/i2c_csr.sv */
// i2c master register file with read mux, command clearing, status and interrupt
`timescale 1ns/1ps

module i2c_csr #(
	parameter logic [i2c_master_pkg::ADDR_W-1:0] BASE_ADDR = '0
) (
	input  logic clk,
	input  logic rst,
	input  logic [i2c_master_pkg::ADDR_W-1:0] io_a_i,
	input  logic [i2c_master_pkg::DATA_W-1:0] io_di_i,
	input  logic io_re_i,
	input  logic io_we_i,
	output logic [i2c_master_pkg::DATA_W-1:0] io_do_o,
	output logic i2c_irq_o,
	output i2c_master_pkg::byte_req_t req_o,
	output logic [i2c_master_pkg::DATA_W-1:0] tx_data_o,
	output logic [i2c_master_pkg::PRESCALE_W-1:0] prescale_o,
	output logic core_en_o,
	input  i2c_master_pkg::byte_rsp_t rsp_i,
	input  logic busy_i
);

	localparam logic [i2c_master_pkg::ADDR_W-1:0] A_PRER_LO = BASE_ADDR + i2c_master_pkg::REG_PRER_LO;
	localparam logic [i2c_master_pkg::ADDR_W-1:0] A_PRER_HI = BASE_ADDR + i2c_master_pkg::REG_PRER_HI;
	localparam logic [i2c_master_pkg::ADDR_W-1:0] A_CTR = BASE_ADDR + i2c_master_pkg::REG_CTR;
	localparam logic [i2c_master_pkg::ADDR_W-1:0] A_TXR = BASE_ADDR + i2c_master_pkg::REG_TXR;
	localparam logic [i2c_master_pkg::ADDR_W-1:0] A_RXR = BASE_ADDR + i2c_master_pkg::REG_RXR;
	localparam logic [i2c_master_pkg::ADDR_W-1:0] A_CR = BASE_ADDR + i2c_master_pkg::REG_CR;
	localparam logic [i2c_master_pkg::ADDR_W-1:0] A_SR = BASE_ADDR + i2c_master_pkg::REG_SR;

	logic [i2c_master_pkg::PRESCALE_W-1:0] prer;
	logic [i2c_master_pkg::DATA_W-1:0] ctr;
	logic [i2c_master_pkg::DATA_W-1:0] txr;
	logic [i2c_master_pkg::DATA_W-1:0] cr;
	logic [i2c_master_pkg::DATA_W-1:0] sr;
	logic rxack;
	logic tip;	// read or write pending
	logic irq_flag;

	assign core_en_o = ctr[7];
	assign prescale_o = prer;
	assign tx_data_o = txr;
	assign req_o = '{start: cr[7], stop: cr[6], read: cr[5], write: cr[4], ack_in: cr[3]};

	// status byte, bits 5 to 2 reserved
	assign sr = {rxack, busy_i, 4'b0000, tip, irq_flag};

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			io_do_o <= '0;
		else if (io_re_i)
		begin
			case (io_a_i)
				A_PRER_LO: io_do_o <= prer[7:0];
				A_PRER_HI: io_do_o <= prer[15:8];
				A_CTR: io_do_o <= ctr;
				A_TXR: io_do_o <= txr;
				A_RXR: io_do_o <= rsp_i.rx_data;
				A_CR: io_do_o <= cr;
				A_SR: io_do_o <= sr;
				default: io_do_o <= '0;
			endcase
		end
		else
			io_do_o <= '0;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			prer <= '1;
			ctr <= '0;
			txr <= '0;
		end
		else if (io_we_i)
		begin
			if (io_a_i == A_PRER_LO)
				prer[7:0] <= io_di_i;
			if (io_a_i == A_PRER_HI)
				prer[15:8] <= io_di_i;
			if (io_a_i == A_CTR)
				ctr <= io_di_i;
			if (io_a_i == A_TXR)
				txr <= io_di_i;
		end
	end

	// command bits self clear, iack lasts one cycle
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			cr <= '0;
		else if (io_we_i && io_a_i == A_CR)
		begin
			if (core_en_o)
				cr <= io_di_i;
		end
		else
		begin
			if (rsp_i.done)
				cr[7:4] <= 4'h0;
			cr[2:0] <= 3'b000;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rxack <= 1'b0;
			tip <= 1'b0;
			irq_flag <= 1'b0;
			i2c_irq_o <= 1'b0;
		end
		else
		begin
			rxack <= rsp_i.ack_out;
			tip <= cr[5] | cr[4];
			irq_flag <= (rsp_i.done | irq_flag) & ~cr[0];
			i2c_irq_o <= irq_flag & ctr[6];	// gated by ien
		end
	end

endmodule

/* src/i2c_byte_engine.sv */
// i2c byte engine, sequences bit commands for start, eight data bits, ack and stop
`timescale 1ns/1ps

module i2c_byte_engine (
	input  logic clk,
	input  logic rst,
	input  i2c_master_pkg::byte_req_t req_i,
	input  logic [i2c_master_pkg::DATA_W-1:0] tx_data_i,
	output i2c_master_pkg::byte_rsp_t rsp_o,
	output i2c_master_pkg::bit_cmd_e bit_cmd_o,
	output logic bit_tx_o,
	input  logic bit_ack_i,
	input  logic bit_rx_i
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_READ,
		ST_WRITE,
		ST_ACK,
		ST_STOP
	} state_e;

	state_e state;
	logic [i2c_master_pkg::DATA_W-1:0] sr;	// shared tx and rx shifter
	logic [2:0] dcnt;
	logic ld;
	logic shift;
	logic done;
	logic ack_out;
	logic go;

	// done is still high the cycle after, so a stale request is not restarted
	assign go = (req_i.read | req_i.write | req_i.stop) & ~done;

	assign rsp_o.done = done;
	assign rsp_o.ack_out = ack_out;
	assign rsp_o.rx_data = sr;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			sr <= '0;
			dcnt <= '0;
		end
		else if (ld)
		begin
			sr <= tx_data_i;
			dcnt <= 3'd7;
		end
		else if (shift)
		begin
			sr <= {sr[6:0], bit_rx_i};
			dcnt <= dcnt - 3'd1;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			bit_cmd_o <= i2c_master_pkg::CMD_NOP;
			bit_tx_o <= 1'b0;
			ld <= 1'b0;
			shift <= 1'b0;
			done <= 1'b0;
			ack_out <= 1'b0;
		end
		else
		begin
			bit_tx_o <= sr[7];	// msb first
			ld <= 1'b0;
			shift <= 1'b0;
			done <= 1'b0;
			case (state)
				ST_IDLE:
					if (go)
					begin
						ld <= 1'b1;
						if (req_i.start)
						begin
							state <= ST_START;
							bit_cmd_o <= i2c_master_pkg::CMD_START;
						end
						else if (req_i.read)
						begin
							state <= ST_READ;
							bit_cmd_o <= i2c_master_pkg::CMD_READ;
						end
						else if (req_i.write)
						begin
							state <= ST_WRITE;
							bit_cmd_o <= i2c_master_pkg::CMD_WRITE;
						end
						else
						begin
							state <= ST_STOP;
							bit_cmd_o <= i2c_master_pkg::CMD_STOP;
						end
					end
				ST_START:
					if (bit_ack_i)
					begin
						ld <= 1'b1;
						state <= req_i.read ? ST_READ : ST_WRITE;
						bit_cmd_o <= req_i.read ? i2c_master_pkg::CMD_READ
							: i2c_master_pkg::CMD_WRITE;
					end
				ST_WRITE:
					if (bit_ack_i)
					begin
						if (dcnt == 3'd0)
						begin
							state <= ST_ACK;
							bit_cmd_o <= i2c_master_pkg::CMD_READ;	// slave ack
						end
						else
							shift <= 1'b1;
					end
				ST_READ:
					if (bit_ack_i)
					begin
						shift <= 1'b1;
						bit_tx_o <= req_i.ack_in;
						if (dcnt == 3'd0)
						begin
							state <= ST_ACK;
							bit_cmd_o <= i2c_master_pkg::CMD_WRITE;	// master ack
						end
					end
				ST_ACK:
					if (bit_ack_i)
					begin
						ack_out <= bit_rx_i;
						bit_tx_o <= 1'b1;
						if (req_i.stop)
						begin
							state <= ST_STOP;
							bit_cmd_o <= i2c_master_pkg::CMD_STOP;
						end
						else
						begin
							state <= ST_IDLE;
							bit_cmd_o <= i2c_master_pkg::CMD_NOP;
							done <= 1'b1;
						end
					end
					else
						bit_tx_o <= req_i.ack_in;
				ST_STOP:
					if (bit_ack_i)
					begin
						state <= ST_IDLE;
						bit_cmd_o <= i2c_master_pkg::CMD_NOP;
						done <= 1'b1;
					end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* src/i2c_bit_engine.sv */
// i2c bit engine, prescaled phase timing, clock stretch wait and line waveforms
`timescale 1ns/1ps

module i2c_bit_engine (
	input  logic clk,
	input  logic rst,
	input  logic core_en_i,
	input  logic [i2c_master_pkg::PRESCALE_W-1:0] prescale_i,
	input  i2c_master_pkg::bit_cmd_e cmd_i,
	input  logic tx_i,
	output logic cmd_ack_o,
	output logic rx_o,
	input  i2c_master_pkg::line_state_t line_i,
	output logic scl_oen_o,
	output logic sda_oen_o
);

	// one hot phases, idle is all zero
	typedef enum logic [16:0] {
		IDLE = 17'h0,
		START_A = 17'h1 << 0,
		START_B = 17'h1 << 1,
		START_C = 17'h1 << 2,
		START_D = 17'h1 << 3,
		START_E = 17'h1 << 4,
		STOP_A = 17'h1 << 5,
		STOP_B = 17'h1 << 6,
		STOP_C = 17'h1 << 7,
		STOP_D = 17'h1 << 8,
		RD_A = 17'h1 << 9,
		RD_B = 17'h1 << 10,
		RD_C = 17'h1 << 11,
		RD_D = 17'h1 << 12,
		WR_A = 17'h1 << 13,
		WR_B = 17'h1 << 14,
		WR_C = 17'h1 << 15,
		WR_D = 17'h1 << 16
	} phase_e;

	phase_e phase;
	logic [i2c_master_pkg::PRESCALE_W-1:0] cnt;
	logic clk_en;	// one cycle per phase
	logic dscl_oen;
	logic slave_wait;

	// scl released by us but still read low means the slave holds it
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			dscl_oen <= 1'b1;
			slave_wait <= 1'b0;
		end
		else
		begin
			dscl_oen <= scl_oen_o;
			slave_wait <= (scl_oen_o & ~dscl_oen & ~line_i.scl) | (slave_wait & ~line_i.scl);
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cnt <= '0;
			clk_en <= 1'b1;
		end
		else if (cnt == '0 || !core_en_i)
		begin
			cnt <= prescale_i;
			clk_en <= 1'b1;
		end
		else
		begin
			if (!slave_wait)
				cnt <= cnt - 1'b1;	// frozen while stretched
			clk_en <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (line_i.scl_rise)
			rx_o <= line_i.rx_bit;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			phase <= IDLE;
			cmd_ack_o <= 1'b0;
			scl_oen_o <= 1'b1;
			sda_oen_o <= 1'b1;
		end
		else
		begin
			cmd_ack_o <= 1'b0;
			if (clk_en)
			begin
				case (phase)
					IDLE:
						case (cmd_i)
							i2c_master_pkg::CMD_START: phase <= START_A;
							i2c_master_pkg::CMD_STOP: phase <= STOP_A;
							i2c_master_pkg::CMD_WRITE: phase <= WR_A;
							i2c_master_pkg::CMD_READ: phase <= RD_A;
							default: phase <= IDLE;
						endcase
					START_A:
					begin
						phase <= START_B;
						sda_oen_o <= 1'b1;	// sda up, also for repeated start
					end
					START_B:
					begin
						phase <= START_C;
						scl_oen_o <= 1'b1;
					end
					START_C:
					begin
						phase <= START_D;
						sda_oen_o <= 1'b0;	// start condition
					end
					START_D: phase <= START_E;
					START_E:
					begin
						phase <= IDLE;
						cmd_ack_o <= 1'b1;
						scl_oen_o <= 1'b0;
					end
					STOP_A:
					begin
						phase <= STOP_B;
						scl_oen_o <= 1'b0;
						sda_oen_o <= 1'b0;
					end
					STOP_B:
					begin
						phase <= STOP_C;
						scl_oen_o <= 1'b1;
					end
					STOP_C: phase <= STOP_D;
					STOP_D:
					begin
						phase <= IDLE;
						cmd_ack_o <= 1'b1;
						sda_oen_o <= 1'b1;	// stop condition
					end
					RD_A:
					begin
						phase <= RD_B;
						scl_oen_o <= 1'b0;
						sda_oen_o <= 1'b1;	// let the slave drive
					end
					RD_B:
					begin
						phase <= RD_C;
						scl_oen_o <= 1'b1;
					end
					RD_C: phase <= RD_D;
					RD_D:
					begin
						phase <= IDLE;
						cmd_ack_o <= 1'b1;
						scl_oen_o <= 1'b0;
					end
					WR_A:
					begin
						phase <= WR_B;
						scl_oen_o <= 1'b0;
						sda_oen_o <= tx_i;
					end
					WR_B:
					begin
						phase <= WR_C;
						scl_oen_o <= 1'b1;
					end
					WR_C: phase <= WR_D;
					WR_D:
					begin
						phase <= IDLE;
						cmd_ack_o <= 1'b1;
						scl_oen_o <= 1'b0;
					end
					default: phase <= IDLE;
				endcase
			end
		end
	end

endmodule

/* src/i2c_line_monitor.sv */
// i2c line monitor, synchronizes scl and sda, tracks bus busy and samples data
`timescale 1ns/1ps

module i2c_line_monitor (
	input  logic clk,
	input  logic rst,
	input  logic scl_i,
	input  logic sda_i,
	output i2c_master_pkg::line_state_t line_o,
	output logic busy_o
);

	logic [1:0] sync_scl;
	logic [1:0] sync_sda;
	logic d_scl;	// previous synchronized level
	logic d_sda;
	logic sta_cond;
	logic sto_cond;
	logic scl_rise;
	logic rx_bit;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			sync_scl <= 2'b11;	// idle bus reads high
			sync_sda <= 2'b11;
			d_scl <= 1'b1;
			d_sda <= 1'b1;
		end
		else
		begin
			sync_scl <= {sync_scl[0], scl_i};
			sync_sda <= {sync_sda[0], sda_i};
			d_scl <= sync_scl[1];
			d_sda <= sync_sda[1];
		end
	end

	// start is sda falling with scl high, stop is sda rising with scl high
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			sta_cond <= 1'b0;
			sto_cond <= 1'b0;
			busy_o <= 1'b0;
			scl_rise <= 1'b0;
		end
		else
		begin
			sta_cond <= ~sync_sda[1] & d_sda & sync_scl[1];
			sto_cond <= sync_sda[1] & ~d_sda & sync_scl[1];
			busy_o <= (sta_cond | busy_o) & ~sto_cond;
			scl_rise <= sync_scl[1] & ~d_scl;
		end
	end

	// data valid in the same cycle as the scl_rise pulse
	always_ff @(posedge clk)
	begin
		if (sync_scl[1] & ~d_scl)
			rx_bit <= sync_sda[1];
	end

	assign line_o = '{scl: sync_scl[1], sda: sync_sda[1], scl_rise: scl_rise, rx_bit: rx_bit};

endmodule

/* src/i2c_master.sv */
// i2c master top, register file with byte engine, bit engine and line monitor
`timescale 1ns/1ps

module i2c_master #(
	parameter logic [i2c_master_pkg::ADDR_W-1:0] BASE_ADDR = '0
) (
	input  logic clk,
	input  logic rst,
	input  logic [i2c_master_pkg::ADDR_W-1:0] io_a_i,
	input  logic [i2c_master_pkg::DATA_W-1:0] io_di_i,
	input  logic io_re_i,
	input  logic io_we_i,
	output logic [i2c_master_pkg::DATA_W-1:0] io_do_o,
	output logic i2c_irq_o,
	input  logic scl_i,
	input  logic sda_i,
	output logic scl_oen_o,	// active low, high releases the line
	output logic sda_oen_o
);

	i2c_master_pkg::byte_req_t req;
	i2c_master_pkg::byte_rsp_t rsp;
	i2c_master_pkg::bit_cmd_e bit_cmd;
	i2c_master_pkg::line_state_t line;
	logic [i2c_master_pkg::DATA_W-1:0] tx_data;
	logic [i2c_master_pkg::PRESCALE_W-1:0] prescale;
	logic core_en;
	logic bit_tx;
	logic bit_ack;
	logic bit_rx;
	logic busy;

	i2c_csr #(.BASE_ADDR(BASE_ADDR)) csr0 (
		.clk(clk), .rst(rst), .io_a_i(io_a_i), .io_di_i(io_di_i), .io_re_i(io_re_i),
		.io_we_i(io_we_i), .io_do_o(io_do_o), .i2c_irq_o(i2c_irq_o), .req_o(req),
		.tx_data_o(tx_data), .prescale_o(prescale), .core_en_o(core_en),
		.rsp_i(rsp), .busy_i(busy)
	);

	i2c_byte_engine byte0 (
		.clk(clk), .rst(rst), .req_i(req), .tx_data_i(tx_data), .rsp_o(rsp),
		.bit_cmd_o(bit_cmd), .bit_tx_o(bit_tx), .bit_ack_i(bit_ack), .bit_rx_i(bit_rx)
	);

	i2c_bit_engine bit0 (
		.clk(clk), .rst(rst), .core_en_i(core_en), .prescale_i(prescale),
		.cmd_i(bit_cmd), .tx_i(bit_tx), .cmd_ack_o(bit_ack), .rx_o(bit_rx),
		.line_i(line), .scl_oen_o(scl_oen_o), .sda_oen_o(sda_oen_o)
	);

	i2c_line_monitor mon0 (
		.clk(clk), .rst(rst), .scl_i(scl_i), .sda_i(sda_i), .line_o(line), .busy_o(busy)
	);

endmodule

/* test/i2c_slave_model.sv */
// behavioral open-drain i2c slave with one storage byte and optional clock stretching
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h2A,
	parameter int STRETCH_CYCLES = 40
) (
	input  logic clk,
	input  logic rst,
	input  logic stretch_i,	// hold scl low after each ack
	input  logic scl_i,
	input  logic sda_i,
	output logic scl_o,	// 0 pulls the line low
	output logic sda_o,
	output logic [7:0] mem_o
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_ADDR,
		S_ACK_A,
		S_WDATA,
		S_ACK_W,
		S_RDATA,
		S_ACK_R
	} state_e;

	state_e state;
	logic scl_d;
	logic sda_d;
	logic rw;
	logic [3:0] bitcnt;
	logic [7:0] shreg;
	logic [5:0] hold_cnt;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			scl_d <= 1'b1;
			sda_d <= 1'b1;
			rw <= 1'b0;
			bitcnt <= '0;
			shreg <= '0;
			hold_cnt <= '0;
			scl_o <= 1'b1;
			sda_o <= 1'b1;
			mem_o <= '0;
		end
		else
		begin
			scl_d <= scl_i;
			sda_d <= sda_i;
			if (hold_cnt != 6'd0)
			begin
				hold_cnt <= hold_cnt - 6'd1;
				if (hold_cnt == 6'd1)
					scl_o <= 1'b1;	// end of stretch
			end
			if (scl_i && scl_d && sda_d && !sda_i)
			begin
				state <= S_ADDR;	// start, also repeated
				bitcnt <= '0;
				sda_o <= 1'b1;
			end
			else if (scl_i && scl_d && !sda_d && sda_i)
			begin
				state <= S_IDLE;	// stop
				sda_o <= 1'b1;
			end
			else if (scl_i && !scl_d)
			begin
				if (state == S_ADDR || state == S_WDATA || state == S_RDATA)
				begin
					shreg <= {shreg[6:0], sda_i};
					bitcnt <= bitcnt + 4'd1;
				end
			end
			else if (!scl_i && scl_d)
			begin
				// sda only changes while scl is low
				case (state)
					S_ADDR:
						if (bitcnt == 4'd8)
						begin
							if (shreg[7:1] == DEV_ADDR)
							begin
								state <= S_ACK_A;
								rw <= shreg[0];
								sda_o <= 1'b0;
							end
							else
								state <= S_IDLE;	// not ours, wait for stop
						end
					S_ACK_A:
					begin
						bitcnt <= '0;
						if (rw)
						begin
							state <= S_RDATA;
							sda_o <= mem_o[7];
						end
						else
						begin
							state <= S_WDATA;
							sda_o <= 1'b1;
						end
						if (stretch_i)
						begin
							scl_o <= 1'b0;
							hold_cnt <= 6'(STRETCH_CYCLES);
						end
					end
					S_WDATA:
						if (bitcnt == 4'd8)
						begin
							mem_o <= shreg;
							sda_o <= 1'b0;
							state <= S_ACK_W;
						end
					S_ACK_W:
					begin
						state <= S_WDATA;
						bitcnt <= '0;
						sda_o <= 1'b1;
						if (stretch_i)
						begin
							scl_o <= 1'b0;
							hold_cnt <= 6'(STRETCH_CYCLES);
						end
					end
					S_RDATA:
						if (bitcnt == 4'd8)
						begin
							state <= S_ACK_R;	// master drives its ack
							sda_o <= 1'b1;
						end
						else
							sda_o <= mem_o[3'd7 - bitcnt[2:0]];
					S_ACK_R: state <= S_IDLE;
					default: state <= S_IDLE;
				endcase
			end
		end
	end

endmodule

/* test/tb_i2c_master.sv */
// testbench for the i2c master, register level transfers against a slave model
`timescale 1ns/1ps

module tb_i2c_master;

	localparam logic [6:0] SLAVE_ADDR = 7'h2A;
	localparam logic [6:0] OTHER_ADDR = 7'h15;
	localparam int TIMEOUT = 20000;	// cycles per wait

	logic clk;
	logic rst;
	logic [i2c_master_pkg::ADDR_W-1:0] io_a;
	logic [i2c_master_pkg::DATA_W-1:0] io_di;
	logic io_re;
	logic io_we;
	logic [i2c_master_pkg::DATA_W-1:0] io_do;
	logic irq;
	logic scl_oen;
	logic sda_oen;
	logic slv_scl;
	logic slv_sda;
	logic stretch;
	logic [7:0] slv_mem;
	wire scl_bus;
	wire sda_bus;

	string name_q[$];
	logic [8:0] exp_q[$];
	logic [8:0] got_q[$];
	int checked;
	logic [7:0] last_wr;	// last byte written to the slave

	// pull-ups, either side can pull low
	assign scl_bus = scl_oen & slv_scl;
	assign sda_bus = sda_oen & slv_sda;

	i2c_master #(.BASE_ADDR(6'd0)) dut0 (
		.clk(clk), .rst(rst), .io_a_i(io_a), .io_di_i(io_di), .io_re_i(io_re),
		.io_we_i(io_we), .io_do_o(io_do), .i2c_irq_o(irq), .scl_i(scl_bus),
		.sda_i(sda_bus), .scl_oen_o(scl_oen), .sda_oen_o(sda_oen)
	);

	i2c_slave_model #(.DEV_ADDR(SLAVE_ADDR)) slave0 (
		.clk(clk), .rst(rst), .stretch_i(stretch), .scl_i(scl_bus), .sda_i(sda_bus),
		.scl_o(slv_scl), .sda_o(slv_sda), .mem_o(slv_mem)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// ack and receive byte at the end of a transfer, read ends in our own nack
	function automatic logic [8:0] expect_rx(input logic [6:0] addr, input logic rd,
		input logic [7:0] last);
		logic ack;
		ack = (addr != SLAVE_ADDR) || rd;
		return {ack, last};
	endfunction

	task automatic put_reg(input logic [5:0] a, input logic [7:0] d);
		@(posedge clk);
		io_a <= a;
		io_di <= d;
		io_we <= 1'b1;
		@(posedge clk);
		io_we <= 1'b0;
	endtask

	task automatic get_reg(input logic [5:0] a, output logic [7:0] d);
		@(posedge clk);
		io_a <= a;
		io_re <= 1'b1;
		@(posedge clk);
		io_re <= 1'b0;
		@(negedge clk);
		d = io_do;	// registered read data
	endtask

	task automatic post_check(input string name, input logic [8:0] exp, input logic [8:0] got);
		name_q.push_back(name);
		exp_q.push_back(exp);
		got_q.push_back(got);
	endtask

	task automatic wait_tip_clear(input string what);
		logic [7:0] sr;
		int cycles;
		cycles = 0;
		get_reg(i2c_master_pkg::REG_SR, sr);
		while (sr[1])
		begin
			if (cycles >= TIMEOUT)
			begin
				$display("timeout: transfer still in progress while waiting for %s", what);
				$display("Test FAILED");
				$fatal(1);
			end
			get_reg(i2c_master_pkg::REG_SR, sr);
			cycles = cycles + 2;
		end
	endtask

	task automatic send_bytes(input string tag, input logic [6:0] addr, input logic [7:0] data);
		logic [7:0] sr;
		logic [8:0] exp;
		exp = expect_rx(addr, 1'b0, data);
		put_reg(i2c_master_pkg::REG_TXR, {addr, 1'b0});
		put_reg(i2c_master_pkg::REG_CR, 8'h90);	// start, write
		wait_tip_clear({tag, " address byte"});
		get_reg(i2c_master_pkg::REG_SR, sr);
		post_check({tag, " address rxack"}, {8'h00, exp[8]}, {8'h00, sr[7]});
		post_check({tag, " busy"}, 9'h001, {8'h00, sr[6]});
		put_reg(i2c_master_pkg::REG_TXR, data);
		put_reg(i2c_master_pkg::REG_CR, 8'h50);	// write, stop
		wait_tip_clear({tag, " data byte"});
		get_reg(i2c_master_pkg::REG_SR, sr);
		post_check({tag, " data rxack"}, {8'h00, exp[8]}, {8'h00, sr[7]});
		post_check({tag, " busy after stop"}, 9'h000, {8'h00, sr[6]});
		last_wr = data;
		post_check({tag, " slave byte"}, {1'b0, last_wr}, {1'b0, slv_mem});
	endtask

	task automatic fetch_byte(input string tag);
		logic [7:0] sr;
		logic [7:0] rx;
		logic [7:0] cr;
		logic [8:0] addr_exp;
		logic [8:0] exp;
		addr_exp = expect_rx(SLAVE_ADDR, 1'b0, last_wr);
		exp = expect_rx(SLAVE_ADDR, 1'b1, last_wr);
		put_reg(i2c_master_pkg::REG_TXR, {SLAVE_ADDR, 1'b1});
		put_reg(i2c_master_pkg::REG_CR, 8'h90);
		wait_tip_clear({tag, " address byte"});
		get_reg(i2c_master_pkg::REG_SR, sr);
		post_check({tag, " address rxack"}, {8'h00, addr_exp[8]}, {8'h00, sr[7]});
		put_reg(i2c_master_pkg::REG_CR, 8'h68);	// read, nack, stop
		wait_tip_clear({tag, " data byte"});
		get_reg(i2c_master_pkg::REG_RXR, rx);
		get_reg(i2c_master_pkg::REG_SR, sr);
		get_reg(i2c_master_pkg::REG_CR, cr);
		post_check({tag, " rxack and data"}, exp, {sr[7], rx});
		// start, stop, read, write and iack, the ack bit keeps its value
		post_check({tag, " command bits"}, 9'h000, {4'h0, cr[7:4], cr[0]});
	endtask

	task automatic probe_addr(input string tag, input logic [6:0] addr);
		logic [7:0] sr;
		logic [8:0] exp;
		exp = expect_rx(addr, 1'b0, last_wr);
		put_reg(i2c_master_pkg::REG_TXR, {addr, 1'b0});
		put_reg(i2c_master_pkg::REG_CR, 8'hd0);	// start, write, stop
		wait_tip_clear(tag);
		get_reg(i2c_master_pkg::REG_SR, sr);
		post_check({tag, " rxack"}, {8'h00, exp[8]}, {8'h00, sr[7]});
	endtask

	always @(posedge clk)
	begin : compare
		string name;
		logic [8:0] exp_v;
		logic [8:0] got_v;
		while (got_q.size() > 0)
		begin
			name = name_q.pop_front();
			exp_v = exp_q.pop_front();
			got_v = got_q.pop_front();
			checked = checked + 1;
			assert (got_v === exp_v)
			else
			begin
				$display("FAILED %s expected %h actual %h", name, exp_v, got_v);
				$display("Test FAILED");
				$fatal(1);
			end
		end
	end

	initial
	begin
		logic [7:0] d;
		logic [7:0] sr;
		int seed_ret;
		seed_ret = $urandom(32'hd0d3_5196);
		rst = 1'b1;
		io_a = '0;
		io_di = '0;
		io_re = 1'b0;
		io_we = 1'b0;
		stretch = 1'b0;
		checked = 0;
		last_wr = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		get_reg(i2c_master_pkg::REG_PRER_LO, d);
		post_check("reset prer_lo", 9'h0ff, {1'b0, d});
		get_reg(i2c_master_pkg::REG_PRER_HI, d);
		post_check("reset prer_hi", 9'h0ff, {1'b0, d});
		get_reg(i2c_master_pkg::REG_CTR, d);
		post_check("reset ctr", 9'h000, {1'b0, d});
		get_reg(i2c_master_pkg::REG_TXR, d);
		post_check("reset txr", 9'h000, {1'b0, d});
		get_reg(i2c_master_pkg::REG_RXR, d);
		post_check("reset rxr", 9'h000, {1'b0, d});
		get_reg(i2c_master_pkg::REG_CR, d);
		post_check("reset cr", 9'h000, {1'b0, d});
		get_reg(i2c_master_pkg::REG_SR, d);
		post_check("reset sr", 9'h000, {1'b0, d});
		post_check("reset scl_oen", 9'h001, {8'h00, scl_oen});
		post_check("reset sda_oen", 9'h001, {8'h00, sda_oen});
		post_check("reset irq", 9'h000, {8'h00, irq});

		put_reg(i2c_master_pkg::REG_PRER_LO, 8'd3);
		put_reg(i2c_master_pkg::REG_PRER_HI, 8'd0);
		put_reg(i2c_master_pkg::REG_CTR, 8'h80);	// core on, irq off

		d = 8'($urandom());
		send_bytes("write", SLAVE_ADDR, d);
		fetch_byte("read");
		probe_addr("wrong address", OTHER_ADDR);

		put_reg(i2c_master_pkg::REG_CR, 8'h01);	// drop flag from earlier transfers
		put_reg(i2c_master_pkg::REG_CTR, 8'hc0);
		probe_addr("irq enabled", OTHER_ADDR);
		get_reg(i2c_master_pkg::REG_SR, sr);
		post_check("irq enabled flag", 9'h001, {8'h00, sr[0]});
		post_check("irq enabled output", 9'h001, {8'h00, irq});
		put_reg(i2c_master_pkg::REG_CR, 8'h01);
		get_reg(i2c_master_pkg::REG_SR, sr);
		post_check("iack flag", 9'h000, {8'h00, sr[0]});
		post_check("iack output", 9'h000, {8'h00, irq});
		put_reg(i2c_master_pkg::REG_CTR, 8'h80);
		probe_addr("irq disabled", OTHER_ADDR);
		get_reg(i2c_master_pkg::REG_SR, sr);
		post_check("irq disabled flag", 9'h001, {8'h00, sr[0]});
		post_check("irq disabled output", 9'h000, {8'h00, irq});
		put_reg(i2c_master_pkg::REG_CR, 8'h01);

		@(posedge clk);
		stretch <= 1'b1;
		d = 8'($urandom());
		send_bytes("stretch write", SLAVE_ADDR, d);
		fetch_byte("stretch read");

		@(posedge clk);
		@(negedge clk);
		if (got_q.size() == 0 && checked > 0)
		begin
			$display("Test OK");
			$finish;
		end
		else
		begin
			$display("Test FAILED");
			$fatal(1);
		end
	end

endmodule

/* i2c_master.f */
src/i2c_master_pkg.sv
src/i2c_csr.sv
src/i2c_byte_engine.sv
src/i2c_bit_engine.sv
src/i2c_line_monitor.sv
src/i2c_master.sv
test/i2c_slave_model.sv
test/tb_i2c_master.sv

/* Bender.yml */
package:
  name: i2c_master

sources:
  - src/i2c_master_pkg.sv
  - src/i2c_csr.sv
  - src/i2c_byte_engine.sv
  - src/i2c_bit_engine.sv
  - src/i2c_line_monitor.sv
  - src/i2c_master.sv
  - target: test
    files:
      - test/i2c_slave_model.sv
      - test/tb_i2c_master.sv
